// File: Bender.yml
package:
  name: ex_stage

sources:
  - common/isa_pkg.sv
  - common/ex_pkg.sv
  - decode/issue_gate.sv
  - execute/alu.sv
  - execute/branch_unit.sv
  - execute/csr_buffer.sv
  - execute/multiplier.sv
  - result/writeback_mux.sv
  - logic/ex_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_ex_stage.sv

// File: common/ex_pkg.sv
// Execute-stage microarchitecture definitions
// scoreboard ID width and write-back source encoding
package ex_pkg;

  // ------------------------------------------------
  // scoreboard
  // ------------------------------------------------
  // 8 entries in flight
  localparam int unsigned DefaultTransIdBits = 3;

  // ------------------------------------------------
  // write-back sources
  // ------------------------------------------------
  // branch link address is the fallback
  typedef enum logic [1:0] {
    SRC_BRANCH,
    SRC_ALU,
    SRC_CSR,
    SRC_MUL
  } res_src_e;

endpackage

// File: common/isa_pkg.sv
// RISC-V instruction-set definitions for the execute stage
// word width, operation codes, exception causes and the CSR operand layout
package isa_pkg;

  // ------------------------------------------------
  // data path
  // ------------------------------------------------
  // RV32 only
  localparam int unsigned Xlen = 32;

  // ------------------------------------------------
  // operation codes
  // ------------------------------------------------
  typedef enum logic [4:0] {
    // arithmetic, logic, shifts, set-less-than
    ADD, SUB, XORL, ORL, ANDL, SLL, SRL, SRA, SLTS, SLTU,
    // conditional branch compares
    EQ, NE, LTS, GES, LTU, GEU,
    // unconditional jumps
    JAL, JALR,
    // csr access
    CSRRW, CSRRS, CSRRC,
    // multiply, low and high halves
    MUL, MULH, MULHU, MULHSU
  } fu_op_e;

  // ------------------------------------------------
  // exceptions
  // ------------------------------------------------
  // mcause 0, instruction address misaligned
  localparam logic [Xlen-1:0] CauseInstrMisaligned = '0;

  // operand b is either plain data or carries the csr address
  typedef union packed {
    logic [Xlen-1:0] data;
    struct packed {
      logic [Xlen-13:0] rsvd;
      logic [11:0]      addr;
    } csr;
  } csr_word_u;

endpackage

// File: decode/issue_gate.sv
// Issue gate for the fixed-latency units
// silences the shared operand bus per unit, flags non-branch issue
`timescale 1ns/1ps

module issue_gate #(
  parameter int unsigned TransIdBits = 3
) (
  input  isa_pkg::fu_op_e                fu_op_i,
  input  logic [isa_pkg::Xlen-1:0]       operand_a_i,
  input  logic [isa_pkg::Xlen-1:0]       operand_b_i,
  input  logic [TransIdBits-1:0]         trans_id_i,
  input  logic                           alu_valid_i,
  input  logic                           branch_valid_i,
  input  logic                           csr_valid_i,
  input  logic                           mult_valid_i,
  output isa_pkg::fu_op_e                alu_op_o,
  output logic [isa_pkg::Xlen-1:0]       alu_a_o,
  output logic [isa_pkg::Xlen-1:0]       alu_b_o,
  output isa_pkg::fu_op_e                mul_op_o,
  output logic [isa_pkg::Xlen-1:0]       mul_a_o,
  output logic [isa_pkg::Xlen-1:0]       mul_b_o,
  output logic [TransIdBits-1:0]         mul_trans_id_o,
  output logic                           other_fu_valid_o
);
  import isa_pkg::*;

  logic alu_sel;

  // alu also does the branch compare
  assign alu_sel = alu_valid_i | branch_valid_i;

  // idle datapaths see all zeros, no toggling
  assign alu_op_o = alu_sel ? fu_op_i : fu_op_e'('0);
  assign alu_a_o  = alu_sel ? operand_a_i : '0;
  assign alu_b_o  = alu_sel ? operand_b_i : '0;

  // multiplier only on its own strobe
  assign mul_op_o       = mult_valid_i ? fu_op_i : fu_op_e'('0);
  assign mul_a_o        = mult_valid_i ? operand_a_i : '0;
  assign mul_b_o        = mult_valid_i ? operand_b_i : '0;
  assign mul_trans_id_o = mult_valid_i ? trans_id_i : '0;

  // any non-branch issue, for the accidental mispredict check
  assign other_fu_valid_o = alu_valid_i | csr_valid_i | mult_valid_i;

endmodule

// File: ex_stage.f
+incdir+tests
common/isa_pkg.sv
common/ex_pkg.sv
decode/issue_gate.sv
execute/alu.sv
execute/branch_unit.sv
execute/csr_buffer.sv
execute/multiplier.sv
result/writeback_mux.sv
logic/ex_stage.sv
tests/tb_ex_stage.sv

// File: execute/alu.sv
// Single-cycle ALU
// add/sub, logic ops, shifts, set-less-than and the branch compare
`timescale 1ns/1ps

module alu (
  input  isa_pkg::fu_op_e          op_i,
  input  logic [isa_pkg::Xlen-1:0] a_i,
  input  logic [isa_pkg::Xlen-1:0] b_i,
  output logic [isa_pkg::Xlen-1:0] result_o,
  output logic                     compare_o
);
  import isa_pkg::*;

  logic [$clog2(Xlen)-1:0] shamt;
  logic                    less_s;
  logic                    less_u;
  logic                    equal;

  // shift amount from the low bits only
  assign shamt = b_i[$clog2(Xlen)-1:0];

  // shared compare terms
  assign less_s = $signed(a_i) < $signed(b_i);
  assign less_u = a_i < b_i;
  assign equal  = a_i == b_i;

  // ------------------------------------------------
  // result
  // ------------------------------------------------
  always_comb begin
    case (op_i)
      ADD:     result_o = a_i + b_i;
      SUB:     result_o = a_i - b_i;
      XORL:    result_o = a_i ^ b_i;
      ORL:     result_o = a_i | b_i;
      ANDL:    result_o = a_i & b_i;
      SLL:     result_o = a_i << shamt;
      SRL:     result_o = a_i >> shamt;
      // arithmetic shift keeps the sign
      SRA:     result_o = $unsigned($signed(a_i) >>> shamt);
      SLTS:    result_o = {{(Xlen-1){1'b0}}, less_s};
      SLTU:    result_o = {{(Xlen-1){1'b0}}, less_u};
      // branches and jumps produce no alu data
      default: result_o = '0;
    endcase
  end

  // ------------------------------------------------
  // branch compare
  // ------------------------------------------------
  always_comb begin
    case (op_i)
      EQ:      compare_o = equal;
      NE:      compare_o = ~equal;
      LTS:     compare_o = less_s;
      GES:     compare_o = ~less_s;
      LTU:     compare_o = less_u;
      GEU:     compare_o = ~less_u;
      default: compare_o = 1'b0;
    endcase
  end

endmodule

// File: execute/branch_unit.sv
// Branch unit
// computes target and link address, resolves against the prediction
// and flags misaligned jump targets
`timescale 1ns/1ps

module branch_unit #(
  parameter bit RvcEn = 1'b1
) (
  input  isa_pkg::fu_op_e          fu_op_i,
  input  logic [isa_pkg::Xlen-1:0] operand_a_i,
  input  logic [isa_pkg::Xlen-1:0] imm_i,
  input  logic [isa_pkg::Xlen-1:0] pc_i,
  input  logic                     is_compressed_i,
  input  logic                     branch_valid_i,
  input  logic                     other_fu_valid_i,
  input  logic                     compare_i,
  input  logic                     predict_taken_i,
  input  logic [isa_pkg::Xlen-1:0] predict_target_i,
  output logic [isa_pkg::Xlen-1:0] link_o,
  output logic                     resolve_o,
  output logic                     taken_o,
  output logic [isa_pkg::Xlen-1:0] target_o,
  output logic                     mispredict_o,
  output logic                     exc_valid_o,
  output logic [isa_pkg::Xlen-1:0] exc_cause_o,
  output logic [isa_pkg::Xlen-1:0] exc_tval_o
);
  import isa_pkg::*;

  logic [Xlen-1:0] next_pc;
  logic [Xlen-1:0] base;
  logic [Xlen-1:0] sum;
  logic [Xlen-1:0] jump_target;
  logic            is_jump;
  logic            taken;

  // fall-through pc, 2 for compressed
  assign next_pc = pc_i + (is_compressed_i ? Xlen'(2) : Xlen'(4));
  assign link_o  = next_pc;

  // jalr is register relative, bit 0 dropped
  assign is_jump     = (fu_op_i == JAL) || (fu_op_i == JALR);
  assign base        = (fu_op_i == JALR) ? operand_a_i : pc_i;
  assign sum         = base + imm_i;
  assign jump_target = (fu_op_i == JALR) ? {sum[Xlen-1:1], 1'b0} : sum;
  assign taken       = is_jump | compare_i;

  // ------------------------------------------------
  // resolution
  // ------------------------------------------------
  always_comb begin
    resolve_o    = 1'b0;
    taken_o      = 1'b0;
    target_o     = next_pc;
    mispredict_o = 1'b0;
    if (branch_valid_i) begin
      resolve_o    = 1'b1;
      taken_o      = taken;
      target_o     = taken ? jump_target : next_pc;
      // wrong direction, or taken to the wrong place
      mispredict_o = (taken != predict_taken_i) ||
                     (taken && (jump_target != predict_target_i));
    end else if (other_fu_valid_i && predict_taken_i) begin
      // frontend predicted a jump on a non-branch, redirect to next pc
      resolve_o    = 1'b1;
      mispredict_o = 1'b1;
    end
  end

  // without compressed support targets must be word aligned
  assign exc_valid_o = branch_valid_i && taken && !RvcEn && jump_target[1];
  assign exc_cause_o = CauseInstrMisaligned;
  assign exc_tval_o  = jump_target;

endmodule

// File: execute/csr_buffer.sv
// CSR buffer
// one entry holding the csr address until the instruction commits
`timescale 1ns/1ps

module csr_buffer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic [isa_pkg::Xlen-1:0] operand_a_i,
  input  isa_pkg::csr_word_u       operand_b_i,
  input  logic                     csr_valid_i,
  input  logic                     csr_commit_i,
  output logic                     ready_o,
  output logic [isa_pkg::Xlen-1:0] result_o,
  output logic [11:0]              csr_addr_o
);

  logic        full_q;
  logic [11:0] addr_q;

  // full entry blocks all further issue
  assign ready_o    = ~full_q;
  // write data goes back unchanged, the csr file does the access on commit
  assign result_o   = operand_a_i;
  assign csr_addr_o = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (flush_i) begin
      full_q <= 1'b0;
    end else if (csr_valid_i) begin
      full_q <= 1'b1;
    end else if (csr_commit_i) begin
      full_q <= 1'b0;
    end
  end

  // address field of operand b
  always_ff @(posedge clk_i) begin
    if (csr_valid_i) begin
      addr_q <= operand_b_i.csr.addr;
    end
  end

endmodule

// File: execute/multiplier.sv
// Fixed one-cycle multiplier
// signed, unsigned and mixed products, low or high half registered with the ID
`timescale 1ns/1ps

module multiplier #(
  parameter int unsigned TransIdBits = 3
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     valid_i,
  input  isa_pkg::fu_op_e          op_i,
  input  logic [isa_pkg::Xlen-1:0] a_i,
  input  logic [isa_pkg::Xlen-1:0] b_i,
  input  logic [TransIdBits-1:0]   trans_id_i,
  output logic [isa_pkg::Xlen-1:0] result_o,
  output logic [TransIdBits-1:0]   trans_id_o,
  output logic                     valid_o,
  output logic                     ready_o
);
  import isa_pkg::*;

  logic              sign_a;
  logic              sign_b;
  logic [Xlen:0]     a_ext;
  logic [Xlen:0]     b_ext;
  logic [2*Xlen+1:0] product;
  logic [Xlen-1:0]   half;
  logic [Xlen-1:0]   result_q;
  logic [TransIdBits-1:0] trans_id_q;
  logic              valid_q;

  // mulhsu takes a signed and b unsigned
  assign sign_a = (op_i == MULH) || (op_i == MULHSU);
  assign sign_b = (op_i == MULH);

  // one extra bit turns every flavour into a signed multiply
  assign a_ext   = {sign_a & a_i[Xlen-1], a_i};
  assign b_ext   = {sign_b & b_i[Xlen-1], b_i};
  // full width product, operands sized by the target
  assign product = $signed(a_ext) * $signed(b_ext);
  assign half    = (op_i == MUL) ? product[Xlen-1:0] : product[2*Xlen-1:Xlen];

  // flush drops the result in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    result_q   <= half;
    trans_id_q <= trans_id_i;
  end

  assign result_o   = result_q;
  assign trans_id_o = trans_id_q;
  assign valid_o    = valid_q;
  // accepts a new op every cycle
  assign ready_o    = 1'b1;

endmodule

// File: logic/ex_stage.sv
// Execute stage, fixed-latency half
// ALU, branch unit, CSR buffer and multiplier behind one issue port
// and one write-back port
`timescale 1ns/1ps

module ex_stage #(
  parameter int unsigned TransIdBits = ex_pkg::DefaultTransIdBits,
  parameter bit          RvcEn       = 1'b1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  // issue bus
  input  isa_pkg::fu_op_e          fu_op_i,
  input  logic [isa_pkg::Xlen-1:0] operand_a_i,
  input  logic [isa_pkg::Xlen-1:0] operand_b_i,
  input  logic [isa_pkg::Xlen-1:0] imm_i,
  input  logic [TransIdBits-1:0]   trans_id_i,
  input  logic [isa_pkg::Xlen-1:0] pc_i,
  input  logic                     is_compressed_i,
  input  logic                     alu_valid_i,
  input  logic                     branch_valid_i,
  input  logic                     csr_valid_i,
  input  logic                     mult_valid_i,
  input  logic                     csr_commit_i,
  input  logic                     predict_taken_i,
  input  logic [isa_pkg::Xlen-1:0] predict_target_i,
  // write-back
  output logic [isa_pkg::Xlen-1:0] flu_result_o,
  output logic [TransIdBits-1:0]   flu_trans_id_o,
  output logic                     flu_valid_o,
  output logic                     flu_ready_o,
  // branch resolution
  output logic                     resolve_branch_o,
  output logic [isa_pkg::Xlen-1:0] resolved_target_o,
  output logic                     resolved_taken_o,
  output logic                     mispredict_o,
  output logic                     branch_exception_valid_o,
  output logic [isa_pkg::Xlen-1:0] branch_exception_cause_o,
  output logic [isa_pkg::Xlen-1:0] branch_exception_tval_o,
  output logic [11:0]              csr_addr_o
);
  import isa_pkg::*;

  fu_op_e                 alu_op;
  fu_op_e                 mul_op;
  logic [Xlen-1:0]        alu_a;
  logic [Xlen-1:0]        alu_b;
  logic [Xlen-1:0]        mul_a;
  logic [Xlen-1:0]        mul_b;
  logic [TransIdBits-1:0] mul_trans_id;
  logic                   other_fu_valid;
  // unit results
  logic [Xlen-1:0]        alu_result;
  logic                   alu_compare;
  logic [Xlen-1:0]        branch_result;
  logic [Xlen-1:0]        csr_result;
  logic                   csr_ready;
  logic [Xlen-1:0]        mult_result;
  logic [TransIdBits-1:0] mult_trans_id;
  logic                   mult_valid;
  logic                   mult_ready;

  // ------------------------------------------------
  // operand silencing
  // ------------------------------------------------
  issue_gate #(
    .TransIdBits (TransIdBits)
  ) u_issue_gate (
    .fu_op_i, .operand_a_i, .operand_b_i, .trans_id_i,
    .alu_valid_i, .branch_valid_i, .csr_valid_i, .mult_valid_i,
    .alu_op_o         (alu_op),
    .alu_a_o          (alu_a),
    .alu_b_o          (alu_b),
    .mul_op_o         (mul_op),
    .mul_a_o          (mul_a),
    .mul_b_o          (mul_b),
    .mul_trans_id_o   (mul_trans_id),
    .other_fu_valid_o (other_fu_valid)
  );

  // ------------------------------------------------
  // single-cycle units
  // ------------------------------------------------
  alu u_alu (
    .op_i      (alu_op),
    .a_i       (alu_a),
    .b_i       (alu_b),
    .result_o  (alu_result),
    .compare_o (alu_compare)
  );

  // sees the raw bus, the compare comes from the alu
  branch_unit #(
    .RvcEn (RvcEn)
  ) u_branch_unit (
    .fu_op_i, .operand_a_i, .imm_i, .pc_i, .is_compressed_i,
    .branch_valid_i, .predict_taken_i, .predict_target_i,
    .other_fu_valid_i (other_fu_valid),
    .compare_i        (alu_compare),
    .link_o           (branch_result),
    .resolve_o        (resolve_branch_o),
    .taken_o          (resolved_taken_o),
    .target_o         (resolved_target_o),
    .mispredict_o,
    .exc_valid_o      (branch_exception_valid_o),
    .exc_cause_o      (branch_exception_cause_o),
    .exc_tval_o       (branch_exception_tval_o)
  );

  csr_buffer u_csr_buffer (
    .clk_i, .rst_ni, .flush_i, .operand_a_i, .operand_b_i,
    .csr_valid_i, .csr_commit_i, .csr_addr_o,
    .ready_o  (csr_ready),
    .result_o (csr_result)
  );

  // ------------------------------------------------
  // multiplier and write-back
  // ------------------------------------------------
  multiplier #(
    .TransIdBits (TransIdBits)
  ) u_multiplier (
    .clk_i, .rst_ni, .flush_i,
    .valid_i    (mult_valid_i),
    .op_i       (mul_op),
    .a_i        (mul_a),
    .b_i        (mul_b),
    .trans_id_i (mul_trans_id),
    .result_o   (mult_result),
    .trans_id_o (mult_trans_id),
    .valid_o    (mult_valid),
    .ready_o    (mult_ready)
  );

  writeback_mux #(
    .TransIdBits (TransIdBits)
  ) u_writeback_mux (
    .alu_valid_i, .branch_valid_i, .csr_valid_i, .trans_id_i,
    .mult_valid_i    (mult_valid),
    .alu_result_i    (alu_result),
    .csr_result_i    (csr_result),
    .mult_result_i   (mult_result),
    .branch_result_i (branch_result),
    .mult_trans_id_i (mult_trans_id),
    .csr_ready_i     (csr_ready),
    .mult_ready_i    (mult_ready),
    .result_o        (flu_result_o),
    .trans_id_o      (flu_trans_id_o),
    .valid_o         (flu_valid_o),
    .ready_o         (flu_ready_o)
  );

endmodule

// File: result/writeback_mux.sv
// Write-back mux for the fixed-latency units
// priority select of result and ID, combined valid and ready
`timescale 1ns/1ps

module writeback_mux #(
  parameter int unsigned TransIdBits = 3
) (
  input  logic                     alu_valid_i,
  input  logic                     branch_valid_i,
  input  logic                     csr_valid_i,
  input  logic                     mult_valid_i,
  input  logic [isa_pkg::Xlen-1:0] alu_result_i,
  input  logic [isa_pkg::Xlen-1:0] csr_result_i,
  input  logic [isa_pkg::Xlen-1:0] mult_result_i,
  input  logic [isa_pkg::Xlen-1:0] branch_result_i,
  input  logic [TransIdBits-1:0]   trans_id_i,
  input  logic [TransIdBits-1:0]   mult_trans_id_i,
  input  logic                     csr_ready_i,
  input  logic                     mult_ready_i,
  output logic [isa_pkg::Xlen-1:0] result_o,
  output logic [TransIdBits-1:0]   trans_id_o,
  output logic                     valid_o,
  output logic                     ready_o
);
  import ex_pkg::*;

  res_src_e sel;

  // alu, csr, mul, branch link address last
  always_comb begin
    if (alu_valid_i) begin
      sel = SRC_ALU;
    end else if (csr_valid_i) begin
      sel = SRC_CSR;
    end else if (mult_valid_i) begin
      sel = SRC_MUL;
    end else begin
      sel = SRC_BRANCH;
    end
  end

  always_comb begin
    case (sel)
      SRC_ALU: result_o = alu_result_i;
      SRC_CSR: result_o = csr_result_i;
      SRC_MUL: result_o = mult_result_i;
      default: result_o = branch_result_i;
    endcase
  end

  // mul ID is a cycle old, all others come from the issue port
  assign trans_id_o = (sel == SRC_MUL) ? mult_trans_id_i : trans_id_i;

  assign valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i;
  assign ready_o = csr_ready_i & mult_ready_i;

endmodule

// File: tests/ex_model.svh
// Reference model of the execute stage
// expected ALU, branch, multiply and write-back values from the ISA rules
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// rv32 register-register ops, shift amount from b[4:0]
function automatic logic [31:0] alu_result_of(input fu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
  logic [63:0] wide;
  wide = {{32{a[31]}}, a} >> b[4:0];
  case (op)
    ADD:     return a + b;
    SUB:     return a + ~b + 32'd1;
    XORL:    return a ^ b;
    ORL:     return a | b;
    ANDL:    return a & b;
    SLL:     return a << b[4:0];
    SRL:     return a >> b[4:0];
    // sign-filled upper word shifted down
    SRA:     return wide[31:0];
    // differing signs decide on their own
    SLTS:    return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
    SLTU:    return {31'd0, a < b};
    default: return 32'd0;
  endcase
endfunction

// conditional branch outcome
function automatic logic cond_taken_of(input fu_op_e op, input logic [31:0] a,
                                       input logic [31:0] b);
  logic lt_s;
  // flipping the sign bit maps signed order onto unsigned order
  lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  case (op)
    EQ:      return a == b;
    NE:      return a != b;
    LTS:     return lt_s;
    GES:     return !lt_s;
    LTU:     return a < b;
    GEU:     return a >= b;
    default: return 1'b0;
  endcase
endfunction

// jalr is register relative with bit 0 cleared, all others pc relative
function automatic logic [31:0] jump_target_of(input fu_op_e op, input logic [31:0] a,
                                               input logic [31:0] imm, input logic [31:0] pc);
  if (op == JALR) begin
    return (a + imm) & 32'hffff_fffe;
  end
  return pc + imm;
endfunction

function automatic logic [31:0] next_pc_of(input logic [31:0] pc, input logic rvc);
  return rvc ? pc + 32'd2 : pc + 32'd4;
endfunction

// 64-bit product of the extended operands, low or high word
function automatic logic [31:0] product_half_of(input fu_op_e op, input logic [31:0] a,
                                                input logic [31:0] b);
  logic [63:0] xa;
  logic [63:0] xb;
  logic [63:0] p;
  xa = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
  xb = (op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
  p  = xa * xb;
  return (op == MUL) ? p[31:0] : p[63:32];
endfunction

// alu, then csr, then mul, link address otherwise
function automatic logic [31:0] writeback_pick(input logic alu_v, input logic csr_v,
                                               input logic mul_v, input logic [31:0] alu_r,
                                               input logic [31:0] csr_r,
                                               input logic [31:0] mul_r,
                                               input logic [31:0] br_r);
  if (alu_v) return alu_r;
  if (csr_v) return csr_r;
  if (mul_v) return mul_r;
  return br_r;
endfunction

`endif

// File: tests/tb_ex_stage.sv
// Testbench for the fixed-latency execute stage
// random ALU, branch, multiply and CSR traffic checked against a reference model
`timescale 1ns/1ps

module tb_ex_stage;
  import isa_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  fu_op_e      fu_op_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  logic [31:0] imm_i;
  logic [2:0]  trans_id_i;
  logic [31:0] pc_i;
  logic        is_compressed_i;
  logic        alu_valid_i;
  logic        branch_valid_i;
  logic        csr_valid_i;
  logic        mult_valid_i;
  logic        csr_commit_i;
  logic        predict_taken_i;
  logic [31:0] predict_target_i;
  logic [31:0] flu_result_o;
  logic [2:0]  flu_trans_id_o;
  logic        flu_valid_o;
  logic        flu_ready_o;
  logic        resolve_branch_o;
  logic [31:0] resolved_target_o;
  logic        resolved_taken_o;
  logic        mispredict_o;
  logic        branch_exception_valid_o;
  logic [31:0] branch_exception_cause_o;
  logic [31:0] branch_exception_tval_o;
  logic [11:0] csr_addr_o;

  // ------------------------------------------------
  // stimulus and scoreboard state
  // ------------------------------------------------
  logic [31:0] lfsr_state = 32'h74e8_e723;
  int          errors = 0;
  int          checks = 0;
  int          timeouts = 0;
  int          waited;
  fu_op_e      op;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm;
  logic [31:0] pc;
  logic [31:0] ptarget;
  logic [31:0] exp_target;
  logic [2:0]  id;
  logic        rvc;
  logic        pt;
  logic        go;
  logic        exp_taken;
  logic        use_flush;
  // mult result due next cycle
  logic        mul_pending;
  logic [31:0] mul_exp;
  logic [2:0]  mul_exp_id;

  `include "ex_model.svh"

  ex_stage dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA300_0000 : lfsr_state >> 1;
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s is %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // strobe holds alu, branch, csr and mult from the msb down
  task automatic issue_op(input fu_op_e o, input logic [31:0] oa, input logic [31:0] ob,
                          input logic [31:0] oimm, input logic [31:0] opc,
                          input logic [2:0] oid, input logic orvc, input logic opt,
                          input logic [31:0] optarget, input logic [3:0] strobe);
    @(posedge clk_i);
    fu_op_i          <= o;
    operand_a_i      <= oa;
    operand_b_i      <= ob;
    imm_i            <= oimm;
    pc_i             <= opc;
    trans_id_i       <= oid;
    is_compressed_i  <= orvc;
    predict_taken_i  <= opt;
    predict_target_i <= optarget;
    {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i} <= strobe;
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i} <= 4'b0000;
    predict_taken_i <= 1'b0;
    csr_commit_i    <= 1'b0;
    flush_i         <= 1'b0;
  endtask

  task automatic check_mult_slot();
    check_word("flu_valid_o", flu_valid_o, mul_pending);
    if (mul_pending) begin
      check_word("flu_result_o", flu_result_o,
                 writeback_pick(1'b0, 1'b0, 1'b1, '0, '0, mul_exp, '0));
      check_word("flu_trans_id_o", flu_trans_id_o, mul_exp_id);
    end
  endtask

  initial begin
    rst_ni           = 1'b0;
    flush_i          = 1'b0;
    fu_op_i          = ADD;
    operand_a_i      = '0;
    operand_b_i      = '0;
    imm_i            = '0;
    trans_id_i       = '0;
    pc_i             = '0;
    is_compressed_i  = 1'b0;
    alu_valid_i      = 1'b0;
    branch_valid_i   = 1'b0;
    csr_valid_i      = 1'b0;
    mult_valid_i     = 1'b0;
    csr_commit_i     = 1'b0;
    predict_taken_i  = 1'b0;
    predict_target_i = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_word("flu_valid_o", flu_valid_o, 1'b0);
    check_word("resolve_branch_o", resolve_branch_o, 1'b0);
    check_word("branch_exception_valid_o", branch_exception_valid_o, 1'b0);
    check_word("flu_ready_o", flu_ready_o, 1'b1);

    // ------------------------------------------------
    // alu ops with an occasional stray taken prediction
    // ------------------------------------------------
    for (int i = 0; i < 200; i++) begin
      op  = fu_op_e'(rand_bits(4) % 10);
      a   = rand_bits(32);
      b   = rand_bits(32);
      pc  = rand_bits(32) & 32'hffff_fffe;
      id  = rand_bits(3);
      rvc = rand_bits(1);
      pt  = (rand_bits(3) == 0);
      issue_op(op, a, b, '0, pc, id, rvc, pt, rand_bits(32), 4'b1000);
      @(negedge clk_i);
      check_word("flu_valid_o", flu_valid_o, 1'b1);
      check_word("flu_result_o", flu_result_o,
                 writeback_pick(1'b1, 1'b0, 1'b0, alu_result_of(op, a, b), '0, '0, '0));
      check_word("flu_trans_id_o", flu_trans_id_o, id);
      check_word("resolve_branch_o", resolve_branch_o, pt);
      if (pt) begin
        check_word("mispredict_o", mispredict_o, 1'b1);
        check_word("resolved_target_o", resolved_target_o, next_pc_of(pc, rvc));
      end
    end

    // ------------------------------------------------
    // conditional branches, jal and jalr
    // ------------------------------------------------
    for (int i = 0; i < 160; i++) begin
      op  = fu_op_e'(5'd10 + 5'(rand_bits(3)));
      a   = rand_bits(32);
      // equal operands now and then
      b   = (rand_bits(2) == 0) ? a : rand_bits(32);
      imm = rand_bits(32);
      pc  = rand_bits(32) & 32'hffff_fffe;
      id  = rand_bits(3);
      rvc = rand_bits(1);
      pt  = rand_bits(1);
      exp_target = jump_target_of(op, a, imm, pc);
      ptarget    = rand_bits(1) ? exp_target : rand_bits(32);
      exp_taken  = (op == JAL || op == JALR) ? 1'b1 : cond_taken_of(op, a, b);
      issue_op(op, a, b, imm, pc, id, rvc, pt, ptarget, 4'b0100);
      @(negedge clk_i);
      check_word("resolve_branch_o", resolve_branch_o, 1'b1);
      check_word("resolved_taken_o", resolved_taken_o, exp_taken);
      check_word("resolved_target_o", resolved_target_o,
                 exp_taken ? exp_target : next_pc_of(pc, rvc));
      check_word("mispredict_o", mispredict_o,
                 (exp_taken != pt) || (exp_taken && exp_target != ptarget));
      check_word("flu_valid_o", flu_valid_o, 1'b1);
      check_word("flu_result_o", flu_result_o,
                 writeback_pick(1'b0, 1'b0, 1'b0, '0, '0, '0, next_pc_of(pc, rvc)));
      check_word("flu_trans_id_o", flu_trans_id_o, id);
      // compressed targets are legal here
      check_word("branch_exception_valid_o", branch_exception_valid_o, 1'b0);
      // misaligned instruction address is cause 0
      check_word("branch_exception_cause_o", branch_exception_cause_o, 32'd0);
      // the taken target doubles as the exception tval
      if (exp_taken) begin
        check_word("branch_exception_tval_o", branch_exception_tval_o, exp_target);
      end
    end

    // ------------------------------------------------
    // multiplier ops mostly back to back with bubbles
    // ------------------------------------------------
    mul_pending = 1'b0;
    for (int i = 0; i < 150; i++) begin
      op = fu_op_e'(5'd21 + 5'(rand_bits(2)));
      a  = rand_bits(32);
      b  = rand_bits(32);
      id = rand_bits(3);
      go = (rand_bits(2) != 0);
      issue_op(op, a, b, '0, '0, id, 1'b0, 1'b0, '0, {3'b000, go});
      @(negedge clk_i);
      check_mult_slot();
      mul_pending = go;
      mul_exp     = product_half_of(op, a, b);
      mul_exp_id  = id;
    end
    go_idle();
    @(negedge clk_i);
    check_mult_slot();

    // ------------------------------------------------
    // csr buffer released by commit or flush
    // ------------------------------------------------
    for (int i = 0; i < 12; i++) begin
      op = fu_op_e'(18 + rand_bits(2) % 3);
      a  = rand_bits(32);
      b  = rand_bits(32);
      id = rand_bits(3);
      issue_op(op, a, b, '0, '0, id, 1'b0, 1'b0, '0, 4'b0010);
      @(negedge clk_i);
      check_word("flu_valid_o", flu_valid_o, 1'b1);
      check_word("flu_result_o", flu_result_o,
                 writeback_pick(1'b0, 1'b1, 1'b0, '0, a, '0, '0));
      check_word("flu_trans_id_o", flu_trans_id_o, id);
      go_idle();
      // held until commit
      repeat (rand_bits(2) + 1) begin
        @(negedge clk_i);
        check_word("flu_ready_o", flu_ready_o, 1'b0);
        check_word("csr_addr_o", csr_addr_o, b[11:0]);
      end
      use_flush = rand_bits(1);
      @(posedge clk_i);
      flush_i      <= use_flush;
      csr_commit_i <= !use_flush;
      go_idle();
      waited = 0;
      @(negedge clk_i);
      while (flu_ready_o !== 1'b1 && waited < 8) begin
        @(negedge clk_i);
        waited++;
      end
      if (flu_ready_o !== 1'b1) begin
        timeouts++;
        $display("Timeout: flu_ready_o stayed low after %s", use_flush ? "flush" : "commit");
      end
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
